//--- logic/memDepPkg.sv
// ========================================
// Shared sizes for the dependency predictor
// Table size and queue depth must be powers of two
// ========================================

package memDepPkg;

    // Instruction address
    localparam int PC_WIDTH = 32;
    localparam int INSN_BYTES = 4;

    // Loads looked up together per rename group
    localparam int LOOKUP_WIDTH = 2;

    // Dependency table, indexed by PC bits 7:2
    localparam int MDT_ENTRY_NUM = 64;
    localparam int MDT_INDEX_BITS = 6;
    localparam logic [MDT_INDEX_BITS-1:0] MDT_LAST_INDEX = MDT_INDEX_BITS'(MDT_ENTRY_NUM - 1);

    // Training request queue
    localparam int TRAIN_QUEUE_DEPTH = 4;
    localparam int TRAIN_PTR_BITS = $clog2(TRAIN_QUEUE_DEPTH);
    localparam int TRAIN_CNT_BITS = $clog2(TRAIN_QUEUE_DEPTH + 1);
    localparam logic [TRAIN_PTR_BITS-1:0] TRAIN_LAST_PTR = TRAIN_PTR_BITS'(TRAIN_QUEUE_DEPTH - 1);
    localparam logic [TRAIN_CNT_BITS-1:0] TRAIN_FULL_CNT = TRAIN_CNT_BITS'(TRAIN_QUEUE_DEPTH);

    // Controller phases
    typedef enum logic [0:0] {
        stClear,
        stRun
    } predState;

    // Prediction source, static per request
    typedef enum logic [1:0] {
        modeLearn,
        modeAlwaysSpec,
        modeNeverSpec
    } predMode;

endpackage

//--- logic/mdtPortIf.sv
// ========================================
// Table ports, two reads and one write
// ========================================

`timescale 1ns/10ps

interface mdtPortIf (
    input logic clk
);

    // Read side, one address per load in the group
    logic [memDepPkg::MDT_INDEX_BITS-1:0] readAddr [memDepPkg::LOOKUP_WIDTH];
    logic                                 readData [memDepPkg::LOOKUP_WIDTH];

    // Single write port
    logic                                 writeEn;
    logic [memDepPkg::MDT_INDEX_BITS-1:0] writeAddr;
    logic                                 writeData;

    // Lookup side
    modport reader (output readAddr, input readData);

    // Clear sweep and training side
    modport writer (output writeEn, writeAddr, writeData);

    // Storage side
    modport tableSide (input clk, readAddr, writeEn, writeAddr, writeData, output readData);

endinterface

//--- logic/mdtRam.sv
// ========================================
// Registered reads, old data on a same-cycle write
// Contents are undefined until the clear sweep ends
// ========================================

`timescale 1ns/10ps

module mdtRam (
    mdtPortIf.tableSide port
);

    // One bit per entry
    // 1 means the load waits for older stores
    logic entries [memDepPkg::MDT_ENTRY_NUM];

    // Write port
    always_ff @(posedge port.clk) begin
        if (port.writeEn) begin
            entries[port.writeAddr] <= port.writeData;
        end
    end

    // Both read ports sample every cycle
    // Nonblocking update keeps the pre-write value on a collision
    always_ff @(posedge port.clk) begin
        for (int i = 0; i < memDepPkg::LOOKUP_WIDTH; i++) begin
            port.readData[i] <= entries[port.readAddr[i]];
        end
    end

endmodule

//--- logic/clearSweep.sv
// ========================================
// Walks all table indices once per reset
// ========================================

`timescale 1ns/10ps

module clearSweep (
    input  logic                                 clk,
    input  logic                                 rst,
    output logic [memDepPkg::MDT_INDEX_BITS-1:0] index,
    output logic                                 last
);

    // Free-running index, restarts at zero on reset
    // Wraps after the last entry, harmless once the controller leaves the clear phase
    always_ff @(posedge clk) begin
        if (rst) begin
            index <= '0;
        end else begin
            index <= index + 1'b1;
        end
    end

    // Final entry of the sweep
    assign last = (index == memDepPkg::MDT_LAST_INDEX);

endmodule

//--- logic/predCtrl.sv
// ========================================
// Clear then run, owns the table write port
// Only reset returns the controller to the clear phase
// ========================================

`timescale 1ns/10ps

module predCtrl (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [memDepPkg::MDT_INDEX_BITS-1:0] sweepIndex,
    input  logic                                 sweepLast,
    input  logic                                 queueValid,
    input  logic [memDepPkg::PC_WIDTH-1:0]       queuePc,
    output logic                                 queuePop,
    output logic                                 running,
    mdtPortIf.writer                             tbl
);

    memDepPkg::predState state;

    // Phase register
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memDepPkg::stClear;
        end else if (state == memDepPkg::stClear && sweepLast) begin
            // Last clear write happens in this cycle
            state <= memDepPkg::stRun;
        end
    end

    assign running = (state == memDepPkg::stRun);

    // Write port steering
    always_comb begin
        if (state == memDepPkg::stClear) begin
            // One zero per cycle at the sweep index
            tbl.writeEn   = 1'b1;
            tbl.writeAddr = sweepIndex;
            tbl.writeData = 1'b0;
        end else begin
            // Violating load learned as dependent
            tbl.writeEn   = queueValid;
            tbl.writeAddr = queuePc[memDepPkg::MDT_INDEX_BITS+1:2];
            tbl.writeData = 1'b1;
        end
    end

    // Head leaves the queue as it is written
    assign queuePop = running && queueValid;

endmodule

//--- logic/trainQueue.sv
// ========================================
// Violating load PCs waiting for the write port
// Closed to new entries during the clear phase
// ========================================

`timescale 1ns/10ps

module trainQueue (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           running,
    input  logic                           trainValid,
    output logic                           trainReady,
    input  logic [memDepPkg::PC_WIDTH-1:0] trainPc,
    output logic                           headValid,
    output logic [memDepPkg::PC_WIDTH-1:0] headPc,
    input  logic                           pop
);

    logic [memDepPkg::PC_WIDTH-1:0]       slots [memDepPkg::TRAIN_QUEUE_DEPTH];
    logic [memDepPkg::TRAIN_PTR_BITS-1:0] wrPtr;
    logic [memDepPkg::TRAIN_PTR_BITS-1:0] rdPtr;
    logic [memDepPkg::TRAIN_CNT_BITS-1:0] count;
    logic                                 push;
    logic                                 doPop;

    // Accept while running and not full
    assign trainReady = running && (count != memDepPkg::TRAIN_FULL_CNT);
    assign push       = trainValid && trainReady;

    // Ignore a pop on an empty queue
    assign headValid = (count != '0);
    assign doPop     = pop && headValid;
    assign headPc    = slots[rdPtr];

    // Payload slots
    always_ff @(posedge clk) begin
        if (push) begin
            slots[wrPtr] <= trainPc;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == memDepPkg::TRAIN_LAST_PTR) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == memDepPkg::TRAIN_LAST_PTR) ? '0 : rdPtr + 1'b1;
            end
            // Simultaneous push and pop keep the count
            if (push && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- logic/lookupStage.sv
// ========================================
// One-cycle lookup, response stalls under back-pressure
// Mode is taken per request and registered with it
// ========================================

`timescale 1ns/10ps

module lookupStage (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 running,
    input  logic                                 pcValid,
    output logic                                 pcReady,
    input  logic [memDepPkg::PC_WIDTH-1:0]       pc,
    input  memDepPkg::predMode                   mode,
    output logic                                 predValid,
    input  logic                                 predReady,
    output logic [memDepPkg::LOOKUP_WIDTH-1:0]   pred,
    mdtPortIf.reader                             tbl
);

    logic [memDepPkg::MDT_INDEX_BITS-1:0] reqAddr  [memDepPkg::LOOKUP_WIDTH];
    logic [memDepPkg::MDT_INDEX_BITS-1:0] heldAddr [memDepPkg::LOOKUP_WIDTH];
    memDepPkg::predMode                   heldMode;

    // Free when idle or when the current response leaves
    assign pcReady = running && (!predValid || predReady);

    // Index of each load in the group
    always_comb begin
        logic [memDepPkg::PC_WIDTH-1:0] loadPc;
        for (int i = 0; i < memDepPkg::LOOKUP_WIDTH; i++) begin
            loadPc     = pc + i * memDepPkg::INSN_BYTES;
            reqAddr[i] = loadPc[memDepPkg::MDT_INDEX_BITS+1:2];
        end
    end

    // Re-read the accepted indices while not accepting
    // Keeps the registered read data on the pending response
    always_comb begin
        for (int i = 0; i < memDepPkg::LOOKUP_WIDTH; i++) begin
            tbl.readAddr[i] = pcReady ? reqAddr[i] : heldAddr[i];
        end
    end

    // Request payload captured on acceptance
    always_ff @(posedge clk) begin
        if (pcValid && pcReady) begin
            heldAddr <= reqAddr;
            heldMode <= mode;
        end
    end

    // Response valid
    always_ff @(posedge clk) begin
        if (rst) begin
            predValid <= 1'b0;
        end else if (pcValid && pcReady) begin
            predValid <= 1'b1;
        end else if (predReady) begin
            predValid <= 1'b0;
        end
    end

    // Mode override of the table bits
    always_comb begin
        for (int i = 0; i < memDepPkg::LOOKUP_WIDTH; i++) begin
            case (heldMode)
                memDepPkg::modeAlwaysSpec: pred[i] = 1'b0;
                memDepPkg::modeNeverSpec:  pred[i] = 1'b1;
                default:                   pred[i] = tbl.readData[i];
            endcase
        end
    end

endmodule

//--- logic/memDepPred.sv
// ========================================
// Memory dependency predictor, two loads per group
// Busy for MDT_ENTRY_NUM cycles after reset
// ========================================

`timescale 1ns/10ps

module memDepPred (
    input  logic                                 clk,
    input  logic                                 rst,

    // Lookup request
    input  logic                                 pcValid,
    output logic                                 pcReady,
    input  logic [memDepPkg::PC_WIDTH-1:0]       pc,
    input  memDepPkg::predMode                   mode,

    // Lookup response, 1 means wait for older stores
    output logic                                 predValid,
    input  logic                                 predReady,
    output logic [memDepPkg::LOOKUP_WIDTH-1:0]   pred,

    // Order violation from the load/store unit
    input  logic                                 trainValid,
    output logic                                 trainReady,
    input  logic [memDepPkg::PC_WIDTH-1:0]       trainPc
);

    logic [memDepPkg::MDT_INDEX_BITS-1:0] sweepIndex;
    logic                                 sweepLast;
    logic                                 queueValid;
    logic [memDepPkg::PC_WIDTH-1:0]       queuePc;
    logic                                 queuePop;
    logic                                 running;

    // Table port bundle
    mdtPortIf tblPort (
        .clk (clk)
    );

    // Storage
    mdtRam i_mdtRam (
        .port (tblPort)
    );

    // Reset-time clear addresses
    clearSweep i_clearSweep (
        .clk   (clk),
        .rst   (rst),
        .index (sweepIndex),
        .last  (sweepLast)
    );

    // Phase control and write steering
    predCtrl i_predCtrl (
        .clk        (clk),
        .rst        (rst),
        .sweepIndex (sweepIndex),
        .sweepLast  (sweepLast),
        .queueValid (queueValid),
        .queuePc    (queuePc),
        .queuePop   (queuePop),
        .running    (running),
        .tbl        (tblPort)
    );

    // Training buffer
    trainQueue i_trainQueue (
        .clk        (clk),
        .rst        (rst),
        .running    (running),
        .trainValid (trainValid),
        .trainReady (trainReady),
        .trainPc    (trainPc),
        .headValid  (queueValid),
        .headPc     (queuePc),
        .pop        (queuePop)
    );

    // Prediction path
    lookupStage i_lookupStage (
        .clk       (clk),
        .rst       (rst),
        .running   (running),
        .pcValid   (pcValid),
        .pcReady   (pcReady),
        .pc        (pc),
        .mode      (mode),
        .predValid (predValid),
        .predReady (predReady),
        .pred      (pred),
        .tbl       (tblPort)
    );

endmodule

//--- test/memDepPredTb.sv
// ========================================
// Testbench for the dependency predictor
// Run from the project root to find test/memdep_testdata.txt
// ========================================

`timescale 1ns/10ps

module memDepPredTb;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int HANDSHAKE_TIMEOUT = 20;
    localparam int CLEAR_TIMEOUT = memDepPkg::MDT_ENTRY_NUM + 16;
    localparam string DATA_FILE = "test/memdep_testdata.txt";

    // Selectors for the handshake wait
    localparam int FLAG_PC_READY = 0;
    localparam int FLAG_TRAIN_READY = 1;
    localparam int FLAG_PRED_VALID = 2;

    logic                                 clk = 1'b0;
    logic                                 rst;
    logic                                 pcValid;
    logic                                 pcReady;
    logic [memDepPkg::PC_WIDTH-1:0]       pc;
    memDepPkg::predMode                   mode;
    logic                                 predValid;
    logic                                 predReady;
    logic [memDepPkg::LOOKUP_WIDTH-1:0]   pred;
    logic                                 trainValid;
    logic                                 trainReady;
    logic [memDepPkg::PC_WIDTH-1:0]       trainPc;
    integer                               seed;

    memDepPred i_dut (
        .clk        (clk),
        .rst        (rst),
        .pcValid    (pcValid),
        .pcReady    (pcReady),
        .pc         (pc),
        .mode       (mode),
        .predValid  (predValid),
        .predReady  (predReady),
        .pred       (pred),
        .trainValid (trainValid),
        .trainReady (trainReady),
        .trainPc    (trainPc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // First error ends the run
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkPred(input logic [memDepPkg::LOOKUP_WIDTH-1:0] actual,
                             input logic [memDepPkg::LOOKUP_WIDTH-1:0] expected,
                             input memDepPkg::predMode m);
        if (actual !== expected) begin
            abortRun($sformatf("mismatch at %0t: pred is %b, expected %b in %s",
                               $time, actual, expected, m.name()));
        end
    endtask

    task automatic checkReady(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            abortRun($sformatf("mismatch at %0t: %s is %b, expected %b",
                               $time, what, actual, expected));
        end
    endtask

    function automatic logic flagValue(input int sel);
        case (sel)
            FLAG_PC_READY:    return pcReady;
            FLAG_TRAIN_READY: return trainReady;
            default:          return predValid;
        endcase
    endfunction

    // Returns at the first falling edge with the flag high
    task automatic waitUntilHigh(input int sel, input int limit, input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!flagValue(sel)) begin
            if (cycles >= limit) begin
                abortRun($sformatf("timeout: %s stayed low for %0d cycles", name, limit));
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // Inputs change just after the rising edge
    task automatic nextDrive();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic lookupOnce(input memDepPkg::predMode m,
                              input logic [memDepPkg::PC_WIDTH-1:0] addr,
                              input logic stall,
                              input logic [memDepPkg::LOOKUP_WIDTH-1:0] expected);
        int stallLen;
        pcValid = 1'b1;
        pc = addr;
        mode = m;
        predReady = !stall;
        waitUntilHigh(FLAG_PC_READY, HANDSHAKE_TIMEOUT, "pcReady");
        nextDrive();
        pcValid = 1'b0;
        if (stall) begin
            stallLen = ($random(seed) & 3) + 2;
            @(negedge clk);
            checkReady(predValid, 1'b1, "predValid after accept");
            checkPred(pred, expected, m);
            // Response must hold and block new requests
            for (int i = 0; i < stallLen; i++) begin
                @(negedge clk);
                checkReady(predValid, 1'b1, "predValid while stalled");
                checkReady(pcReady, 1'b0, "pcReady while stalled");
                checkPred(pred, expected, m);
            end
            nextDrive();
            predReady = 1'b1;
        end
        waitUntilHigh(FLAG_PRED_VALID, HANDSHAKE_TIMEOUT, "predValid");
        checkPred(pred, expected, m);
        nextDrive();
    endtask

    // Second request accepted as the first response leaves
    task automatic lookupPair(input memDepPkg::predMode m,
                              input logic [memDepPkg::PC_WIDTH-1:0] pcA,
                              input logic [memDepPkg::LOOKUP_WIDTH-1:0] expA,
                              input logic [memDepPkg::PC_WIDTH-1:0] pcB,
                              input logic [memDepPkg::LOOKUP_WIDTH-1:0] expB);
        pcValid = 1'b1;
        pc = pcA;
        mode = m;
        predReady = 1'b1;
        waitUntilHigh(FLAG_PC_READY, HANDSHAKE_TIMEOUT, "pcReady");
        nextDrive();
        pc = pcB;
        waitUntilHigh(FLAG_PRED_VALID, HANDSHAKE_TIMEOUT, "predValid");
        checkPred(pred, expA, m);
        checkReady(pcReady, 1'b1, "pcReady as a response leaves");
        nextDrive();
        pcValid = 1'b0;
        waitUntilHigh(FLAG_PRED_VALID, HANDSHAKE_TIMEOUT, "predValid");
        checkPred(pred, expB, m);
        nextDrive();
    endtask

    task automatic sendTrain(input logic [memDepPkg::PC_WIDTH-1:0] addr);
        trainValid = 1'b1;
        trainPc = addr;
        waitUntilHigh(FLAG_TRAIN_READY, HANDSHAKE_TIMEOUT, "trainReady");
        nextDrive();
        trainValid = 1'b0;
    endtask

    // One operation per line
    // Lines starting with # are comments
    task automatic runFile();
        int fd;
        int n;
        int modeVal;
        int stallVal;
        int idleCycles;
        string line;
        logic [7:0] opCode;
        logic [memDepPkg::PC_WIDTH-1:0] pcA;
        logic [memDepPkg::PC_WIDTH-1:0] pcB;
        logic [memDepPkg::LOOKUP_WIDTH-1:0] expA;
        logic [memDepPkg::LOOKUP_WIDTH-1:0] expB;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            abortRun("could not open the test data file");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n <= 1 || line.getc(0) == "#") begin
                continue;
            end
            opCode = line.getc(0);
            case (opCode)
                "L": begin
                    n = $sscanf(line, "%c %d %h %d %b", opCode, modeVal, pcA, stallVal, expA);
                    if (n != 5) abortRun("badly formed lookup line in test data");
                    lookupOnce(memDepPkg::predMode'(modeVal[1:0]), pcA, stallVal != 0, expA);
                end
                "B": begin
                    n = $sscanf(line, "%c %d %h %b %h %b",
                                opCode, modeVal, pcA, expA, pcB, expB);
                    if (n != 6) abortRun("badly formed pair line in test data");
                    lookupPair(memDepPkg::predMode'(modeVal[1:0]), pcA, expA, pcB, expB);
                end
                "T": begin
                    n = $sscanf(line, "%c %h", opCode, pcA);
                    if (n != 2) abortRun("badly formed train line in test data");
                    sendTrain(pcA);
                end
                "I": begin
                    n = $sscanf(line, "%c %d", opCode, idleCycles);
                    if (n != 2) abortRun("badly formed idle line in test data");
                    repeat (idleCycles) nextDrive();
                end
                default: abortRun("unknown operation in the test data");
            endcase
        end
        $fclose(fd);
    endtask

    initial begin
        seed = 39;
        rst = 1'b1;
        pcValid = 1'b0;
        pc = '0;
        mode = memDepPkg::modeLearn;
        predReady = 1'b1;
        trainValid = 1'b0;
        trainPc = '0;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        // Handshakes closed for every cycle of the clear sweep
        repeat (memDepPkg::MDT_ENTRY_NUM) begin
            @(negedge clk);
            checkReady(pcReady, 1'b0, "pcReady during clear");
            checkReady(trainReady, 1'b0, "trainReady during clear");
            checkReady(predValid, 1'b0, "predValid during clear");
        end
        waitUntilHigh(FLAG_PC_READY, CLEAR_TIMEOUT, "pcReady after clear");
        checkReady(trainReady, 1'b1, "trainReady after clear");
        nextDrive();

        runFile();

        $display("All tests passed");
        $finish;
    end

endmodule

//--- test/memdep_testdata.txt
# L mode(0 learn 1 always-spec 2 never-spec) pc(hex) stall(0/1) expected(bin, bit0 = load at pc)
# B mode pcA(hex) expA(bin) pcB(hex) expB(bin) | T pc(hex) | I idle cycles
L 0 00001000 0 00
L 0 000010fc 0 00
T 00001040
I 8
L 0 00001040 0 01
L 0 0000103c 0 10
L 0 00001140 0 01
L 0 00003040 0 01
L 0 00001044 0 00
L 1 00001040 0 00
L 2 00001000 0 11
L 2 00001040 0 11
L 0 00001040 1 01
L 1 0000103c 1 00
B 0 00001040 01 0000103c 10
B 2 00001000 11 00001040 11
T 00002000
T 00002014
T 00002028
T 0000203c
I 8
L 0 00002000 0 01
L 0 00002010 0 10
L 0 00002028 0 01
L 0 00002038 1 10
B 0 00002014 01 00002024 10

//--- tb.f
logic/memDepPkg.sv
logic/mdtPortIf.sv
logic/mdtRam.sv
logic/clearSweep.sv
logic/predCtrl.sv
logic/trainQueue.sv
logic/lookupStage.sv
logic/memDepPred.sv
test/memDepPredTb.sv

//--- Makefile
# Verilator build and run for the memory dependency predictor

VERILATOR ?= verilator
TOP       ?= memDepPredTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= All tests passed

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only if the simulation prints the pass line
run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
